//--- decode_core.f
core_isa_pkg.sv
core_ctrl_pkg.sv
decode.sv
program_counter.sv
cycle_sequencer.sv
decode_core.sv
decode_core_props.sv
decode_core_tb.sv

//--- Makefile
# Verilator build and run of the decode core testbench

VERILATOR ?= verilator
TOP       ?= decode_core_tb
FILELIST  ?= decode_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- decode_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_core_tb import core_isa_pkg::*, core_ctrl_pkg::*; ();

    localparam logic [OPCODE_W-1:0] RESET_PC = 12'hFF2;   // Directed block runs over the wrap
    localparam int SEED            = 1417;
    localparam int NUM_INSTR       = 3000;
    localparam int MAX_TICKS       = 12;
    localparam int CYCLES_PER_TICK = 4;                   // Margin over a 2 cycle enable spacing
    localparam int TIMEOUT_CYCLES  = NUM_INSTR * MAX_TICKS * CYCLES_PER_TICK;

    logic                clk;
    logic                rst;
    logic                clk_2x_en;
    logic [OPCODE_W-1:0] rom_data;
    logic [OPCODE_W-1:0] rom_addr;
    logic                issue;
    issue_info_t         issue_info;
    logic                retire;
    logic                int_disable;

    logic [OPCODE_W-1:0] rom [0:(1 << OPCODE_W)-1];
    logic [OPCODE_W-1:0] dir_op [16];                     // Directed opcodes
    decode_result_t      dir_res [16];                    // and their expected decode
    int                  n_dir = 0;

    logic [OPCODE_W-1:0] model_pc = RESET_PC;
    logic                busy = 1'b0;                     // Model is inside an instruction
    logic                issue_due = 1'b0;
    logic                addr_known = 1'b0;
    issue_info_t         exp_info;
    issue_info_t         act_info;
    logic                exp_retire;
    logic                exp_int;
    logic [31:0]         en_rnd;
    int                  ticks = 0;
    int                  retired = 0;
    int                  cycles = 0;

    decode_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .clk_2x_en   (clk_2x_en),
        .rom_data    (rom_data),
        .rom_addr    (rom_addr),
        .issue       (issue),
        .issue_info  (issue_info),
        .retire      (retire),
        .int_disable (int_disable)
    );

    bind cycle_sequencer decode_core_props u_props (
        .clk         (clk),
        .rst         (rst),
        .decode_en   (decode_en),
        .issue       (issue),
        .retire      (retire),
        .int_disable (int_disable),
        .state       (state)
    );

    assign rom_data = rom[rom_addr];                      // Asynchronous program ROM

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_issue(input string name, input issue_info_t exp, input issue_info_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_pc(input string name, input logic [OPCODE_W-1:0] exp,
                            input logic [OPCODE_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic add_directed(input logic [OPCODE_W-1:0] addr, input logic [OPCODE_W-1:0] op,
                                input logic [UCODE_ADDR_W-1:0] ucode, input instr_length len,
                                input logic skip, input logic no_int);
        rom[addr]                        = op;
        dir_op[n_dir]                    = op;
        dir_res[n_dir].ucode_addr        = ucode;
        dir_res[n_dir].cycle_length      = len;
        dir_res[n_dir].skip_pc_increment = skip;
        dir_res[n_dir].disable_interrupt = no_int;
        dir_res[n_dir].immed             = op[IMMED_W-1:0];
        n_dir++;
    endtask

    // Group rules of the instruction set; entry points only for directed opcodes
    function automatic decode_result_t model_decode(input logic [OPCODE_W-1:0] op,
                                                    output logic known);
        decode_result_t r;
        logic [3:0]     m;
        logic [3:0]     l;
        logic           valid;
        m       = op[7:4];
        l       = op[3:0];
        r       = '0;
        r.immed = op[IMMED_W-1:0];
        valid   = 1'b1;
        case (op[11:8])
            4'h1: begin
                r.cycle_length      = CYCLE12;
                r.skip_pc_increment = 1'b1;
            end
            4'h4, 4'h5: begin
                r.cycle_length      = CYCLE7;
                r.skip_pc_increment = 1'b1;
            end
            4'hA, 4'hC, 4'hD: r.cycle_length = CYCLE7;
            4'hE: begin
                r.disable_interrupt = (m == 4'h4) || (m == 4'h5);   // PSET
                valid = !((m == 4'hD) || (m >= 4'h9 && m <= 4'hB && l >= 4'hC));
            end
            4'hF: begin
                if (m <= 4'h7) begin
                    r.cycle_length = CYCLE7;
                    valid          = (m != 4'h2 && m != 4'h3) || l >= 4'h8;
                end else if (m == 4'hD && l == 4'hE) begin
                    r.cycle_length = CYCLE12;                 // RETS
                end else if ((m == 4'hD || m == 4'hF) && l == 4'hF) begin
                    r.cycle_length      = CYCLE7;             // RET and NOP7
                    r.skip_pc_increment = (m == 4'hD);
                end else begin
                    r.skip_pc_increment = (m == 4'hE) && (l == 4'h8);   // JPBA
                    case (m)
                        4'hC, 4'hD: valid = (l <= 4'hB);
                        4'hE:       valid = (l <= 4'h8);
                        4'hF:       valid = (l <= 4'h9) || (l == 4'hB);
                        default:    valid = 1'b1;
                    endcase
                end
            end
            default: ;
        endcase
        if (!valid) begin
            r.cycle_length      = CYCLE5;
            r.skip_pc_increment = 1'b0;
            r.disable_interrupt = 1'b0;
        end
        known = !valid;                                    // Invalid opcodes go to entry 0
        for (int i = 0; i < n_dir; i++) begin
            if (dir_op[i] == op) begin
                r     = dir_res[i];
                known = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic int ticks_for(input instr_length len);
        case (len)
            CYCLE7:  return 7;
            CYCLE12: return 12;
            default: return 5;
        endcase
    endfunction

    function automatic logic [OPCODE_W-1:0] next_pc(input logic [OPCODE_W-1:0] pc,
                                                    input decode_result_t d);
        if (d.skip_pc_increment) begin
            return {pc[OPCODE_W-1:IMMED_W], d.immed};     // Jump inside the page
        end else begin
            return pc + 12'd1;
        end
    endfunction

    initial begin
        logic [31:0] r;
        void'($urandom(SEED));
        rst       = 1'b1;
        clk_2x_en = 1'b0;
        for (int i = 0; i < (1 << OPCODE_W); i++) begin
            r      = $urandom();
            rom[i] = r[OPCODE_W-1:0];
        end
        add_directed(12'hFF2, 12'h0A5, 7'd0,  CYCLE5,  1'b0, 1'b0);   // JP s
        add_directed(12'hFF3, 12'h1F4, 7'd1,  CYCLE12, 1'b1, 1'b0);   // RETD to FF4
        add_directed(12'hFF4, 12'hE45, 7'd36, CYCLE5,  1'b0, 1'b1);   // PSET
        add_directed(12'hFF5, 12'hFDE, 7'd87, CYCLE12, 1'b0, 1'b0);   // RETS
        add_directed(12'hFF6, 12'hFFF, 7'd97, CYCLE7,  1'b0, 1'b0);   // NOP7
        add_directed(12'hFF7, 12'hE9C, 7'd0,  CYCLE5,  1'b0, 1'b0);   // Invalid
        add_directed(12'hFF8, 12'hFDC, 7'd0,  CYCLE5,  1'b0, 1'b0);   // Invalid
        add_directed(12'hFF9, 12'hFD8, 7'd83, CYCLE5,  1'b0, 1'b0);   // POP YH
        add_directed(12'hFFA, 12'h4FB, 7'd4,  CYCLE7,  1'b1, 1'b0);   // CALL to FFB
        add_directed(12'hFFB, 12'h5FC, 7'd5,  CYCLE7,  1'b1, 1'b0);   // CALZ to FFC
        add_directed(12'hFFC, 12'hC85, 7'd29, CYCLE7,  1'b0, 1'b0);   // AND r, i
        add_directed(12'hFFD, 12'hF2A, 7'd57, CYCLE7,  1'b0, 1'b0);   // ACPX MX, r
        add_directed(12'hFFE, 12'hE5C, 7'd36, CYCLE5,  1'b0, 1'b1);   // PSET
        add_directed(12'hFFF, 12'hFFB, 7'd96, CYCLE5,  1'b0, 1'b0);   // NOP5, then wrap
        add_directed(12'h000, 12'hFDF, 7'd88, CYCLE7,  1'b1, 1'b0);   // RET to 0DF
        add_directed(12'h0DF, 12'hFE8, 7'd91, CYCLE5,  1'b1, 1'b0);   // JPBA to 0E8
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (retired == NUM_INSTR);
        @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

    always @(posedge clk) begin
        en_rnd = $urandom();
        clk_2x_en <= rst ? 1'b0 : en_rnd[0];              // About half of the cycles
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the DUT did not retire all instructions in time");
        end
    end

    // Outputs are sampled mid-cycle, where they are stable
    always @(negedge clk) begin
        if (rst) begin
            if (cycles > 0) begin                         // PC is loaded from the first edge on
                check_pc("reset rom_addr", RESET_PC, rom_addr);
                check_strobe("reset issue", 1'b0, issue);
                check_strobe("reset retire", 1'b0, retire);
                check_strobe("reset int_disable", 1'b0, int_disable);
            end
        end else begin
            exp_retire = 1'b0;
            exp_int    = 1'b0;
            check_pc("rom_addr", model_pc, rom_addr);
            check_strobe("issue", issue_due, issue);
            if (issue_due) begin
                act_info = issue_info;
                if (!addr_known) begin
                    act_info.dec.ucode_addr = '0;
                end
                check_issue("issue_info", exp_info, act_info);
            end
            issue_due = 1'b0;
            if (clk_2x_en && !busy) begin                 // Decode tick
                exp_info.pc  = model_pc;
                exp_info.dec = model_decode(rom[model_pc], addr_known);
                busy         = 1'b1;
                issue_due    = 1'b1;
                ticks        = 1;
            end else if (clk_2x_en) begin
                ticks++;
                if (ticks == ticks_for(exp_info.dec.cycle_length)) begin
                    exp_retire = 1'b1;
                    exp_int    = exp_info.dec.disable_interrupt;
                    busy       = 1'b0;
                    model_pc   = next_pc(model_pc, exp_info.dec);
                    retired++;
                end
            end
            check_strobe("retire", exp_retire, retire);
            check_strobe("int_disable", exp_int, int_disable);
        end
    end

endmodule

`default_nettype wire

//--- decode_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module decode_core_props import core_isa_pkg::*, core_ctrl_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       decode_en,
    input logic       issue,
    input logic       retire,
    input logic       int_disable,
    input seq_state_t state
);

    // Issue and retire are single-cycle strobes
    issue_one_cycle: assert property (@(posedge clk) disable iff (rst) issue |=> !issue)
        else $error("issue was high in two cycles in a row");

    retire_one_cycle: assert property (@(posedge clk) disable iff (rst) retire |=> !retire)
        else $error("retire was high in two cycles in a row");

    int_disable_with_retire: assert property (@(posedge clk) int_disable |-> retire)
        else $error("int_disable pulsed without retire");

    issue_apart_from_decode: assert property (@(posedge clk) !(issue && decode_en))
        else $error("issue and decode_en were high in the same cycle");

    // Combinational strobes stay low while in reset
    reset_quiet: assert property (@(posedge clk) rst |-> !retire && !int_disable)
        else $error("retire or int_disable high during reset");

    // Registered issue and the FSM clear one cycle into reset
    reset_state: assert property (@(posedge clk) rst |=> !issue && state == SEQ_DECODE)
        else $error("issue or sequencer state not cleared by reset");

endmodule

`default_nettype wire

//--- decode_core.sv
`timescale 1ns/1ps
`default_nettype none

module decode_core import core_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter logic [OPCODE_W-1:0] RESET_PC = 12'h100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_2x_en,
    input  logic [OPCODE_W-1:0] rom_data,
    output logic [OPCODE_W-1:0] rom_addr,        // Current PC
    output logic                issue,
    output issue_info_t         issue_info,
    output logic                retire,
    output logic                int_disable
);

    logic           decode_en;
    decode_result_t dec;

    program_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .dec    (dec),
        .pc     (rom_addr)
    );

    decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .decode_en (decode_en),
        .opcode    (rom_data),                   // Asynchronous ROM read of rom_addr
        .dec       (dec)
    );

    cycle_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .clk_2x_en   (clk_2x_en),
        .dec         (dec),
        .pc          (rom_addr),
        .decode_en   (decode_en),
        .issue       (issue),
        .issue_info  (issue_info),
        .retire      (retire),
        .int_disable (int_disable)
    );

endmodule

`default_nettype wire

//--- cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer import core_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_2x_en,
    input  decode_result_t      dec,
    input  logic [OPCODE_W-1:0] pc,
    output logic                decode_en,
    output logic                issue,
    output issue_info_t         issue_info,
    output logic                retire,
    output logic                int_disable
);

    seq_state_t          state;
    logic [TICK_W-1:0]   ticks_left;                 // Zero until loaded on tick 2
    logic [TICK_W-1:0]   len_ticks;                  // Total ticks of the decoded instruction
    logic [OPCODE_W-1:0] pc_q;                       // PC of the instruction in flight

    always_comb begin
        case (dec.cycle_length)
            CYCLE7:  len_ticks = TICKS_CYCLE7;
            CYCLE12: len_ticks = TICKS_CYCLE12;
            default: len_ticks = TICKS_CYCLE5;
        endcase
    end

    assign decode_en   = clk_2x_en && (state == SEQ_DECODE);
    assign retire      = clk_2x_en && (state == SEQ_EXEC) && (ticks_left == 4'd1);
    assign int_disable = retire && dec.disable_interrupt;
    assign issue_info  = '{pc: pc_q, dec: dec};      // dec is valid from the issue cycle on

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_DECODE;
            ticks_left <= '0;
            issue      <= 1'b0;
        end else begin
            issue <= decode_en;                      // One cycle after the decode tick
            if (clk_2x_en) begin
                case (state)
                    SEQ_DECODE: begin
                        state      <= SEQ_EXEC;
                        ticks_left <= '0;
                    end
                    SEQ_EXEC: begin
                        if (ticks_left == '0) begin
                            // Decode tick and this one are spent
                            ticks_left <= len_ticks - 4'd2;
                        end else if (retire) begin
                            state      <= SEQ_DECODE;
                            ticks_left <= '0;
                        end else begin
                            ticks_left <= ticks_left - 1'b1;
                        end
                    end
                    default: state <= SEQ_DECODE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            pc_q <= pc;
        end
    end

endmodule

`default_nettype wire

//--- program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter import core_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter logic [OPCODE_W-1:0] RESET_PC = 12'h100
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                retire,
    input  decode_result_t      dec,
    output logic [OPCODE_W-1:0] pc
);

    logic [OPCODE_W-1:0] pc_next;

    // Jumps stay in the current page; stepping wraps at the top of memory
    always_comb begin
        if (dec.skip_pc_increment) begin
            pc_next = {pc[OPCODE_W-1 -: PAGE_W], dec.immed};   // Page bits with target
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (retire) begin
            pc <= pc_next;                           // Only moves when an instruction ends
        end
    end

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import core_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  logic [OPCODE_W-1:0] opcode,
    output decode_result_t      dec
);

    // Microcode entry of one opcode
    typedef struct packed {
        logic [UCODE_ADDR_W-1:0] addr;
        instr_length             len;
    } uop_t;

    uop_t uop;
    logic skip;                                      // Skip flag of the opcode
    logic no_int;                                    // Interrupt disable of the opcode

    always_comb begin
        uop    = '{7'd0, CYCLE5};                    // Undefined encodings end up here
        skip   = 1'b0;
        no_int = 1'b0;
        casez (opcode)
            12'h0??: uop = '{7'd0, CYCLE5};          // JP s
            12'h1??: begin                           // RETD e
                uop  = '{7'd1, CYCLE12};
                skip = 1'b1;
            end
            12'h2??: uop = '{7'd2, CYCLE5};          // JP C, s
            12'h3??: uop = '{7'd3, CYCLE5};          // JP NC, s
            12'h4??: begin                           // CALL s
                uop  = '{7'd4, CYCLE7};
                skip = 1'b1;
            end
            12'h5??: begin                           // CALZ s
                uop  = '{7'd5, CYCLE7};
                skip = 1'b1;
            end
            12'h6??: uop = '{7'd6, CYCLE5};          // JP Z, s
            12'h7??: uop = '{7'd7, CYCLE5};          // JP NZ, s
            12'h8??: uop = '{7'd8, CYCLE5};          // LD Y, e
            12'h9??: uop = '{7'd9, CYCLE5};          // LBPX MX, e
            12'hA0?: uop = '{7'd10, CYCLE7};         // ADC XH, i
            12'hA1?: uop = '{7'd11, CYCLE7};         // ADC XL, i
            12'hA2?: uop = '{7'd12, CYCLE7};         // ADC YH, i
            12'hA3?: uop = '{7'd13, CYCLE7};         // ADC YL, i
            12'hA4?: uop = '{7'd14, CYCLE7};         // CP XH, i
            12'hA5?: uop = '{7'd15, CYCLE7};         // CP XL, i
            12'hA6?: uop = '{7'd16, CYCLE7};         // CP YH, i
            12'hA7?: uop = '{7'd17, CYCLE7};         // CP YL, i
            12'hA8?: uop = '{7'd18, CYCLE7};         // ADD r, q
            12'hA9?: uop = '{7'd19, CYCLE7};         // ADC r, q
            12'hAA?: uop = '{7'd20, CYCLE7};         // SUB r, q
            12'hAB?: uop = '{7'd21, CYCLE7};         // SBC r, q
            12'hAC?: uop = '{7'd22, CYCLE7};         // AND r, q
            12'hAD?: uop = '{7'd23, CYCLE7};         // OR r, q
            12'hAE?: uop = '{7'd24, CYCLE7};         // XOR r, q
            12'hAF?: uop = '{7'd25, CYCLE7};         // RLC r
            12'hB??: uop = '{7'd26, CYCLE5};         // LD X, e
            12'hC??: begin
                case (opcode[7:6])
                    2'b00:   uop = '{7'd27, CYCLE7}; // ADD r, i
                    2'b01:   uop = '{7'd28, CYCLE7}; // ADC r, i
                    2'b10:   uop = '{7'd29, CYCLE7}; // AND r, i
                    default: uop = '{7'd30, CYCLE7}; // OR r, i
                endcase
            end
            12'hD??: begin
                case (opcode[7:6])
                    2'b00:   uop = '{7'd31, CYCLE7}; // XOR r, i
                    2'b01:   uop = '{7'd32, CYCLE7}; // SBC r, i
                    2'b10:   uop = '{7'd33, CYCLE7}; // FAN r, i
                    default: uop = '{7'd34, CYCLE7}; // CP r, i
                endcase
            end
            12'hE??: begin
                casez (opcode[7:0])
                    8'b00??_????: uop = '{7'd35, CYCLE5};   // LD r, i
                    8'b010?_????: begin                     // PSET p
                        uop    = '{7'd36, CYCLE5};
                        no_int = 1'b1;
                    end
                    8'b0110_????: uop = '{7'd37, CYCLE5};   // LDPX MX, i
                    8'b0111_????: uop = '{7'd38, CYCLE5};   // LDPY MY, i
                    8'b1000_00??: uop = '{7'd39, CYCLE5};   // LD XP, r
                    8'b1000_01??: uop = '{7'd40, CYCLE5};   // LD XH, r
                    8'b1000_10??: uop = '{7'd41, CYCLE5};   // LD XL, r
                    8'b1000_11??: uop = '{7'd42, CYCLE5};   // RRC r
                    8'b1001_00??: uop = '{7'd43, CYCLE5};   // LD YP, r
                    8'b1001_01??: uop = '{7'd44, CYCLE5};   // LD YH, r
                    8'b1001_10??: uop = '{7'd45, CYCLE5};   // LD YL, r
                    8'b1010_00??: uop = '{7'd46, CYCLE5};   // LD r, XP
                    8'b1010_01??: uop = '{7'd47, CYCLE5};   // LD r, XH
                    8'b1010_10??: uop = '{7'd48, CYCLE5};   // LD r, XL
                    8'b1011_00??: uop = '{7'd49, CYCLE5};   // LD r, YP
                    8'b1011_01??: uop = '{7'd50, CYCLE5};   // LD r, YH
                    8'b1011_10??: uop = '{7'd51, CYCLE5};   // LD r, YL
                    8'b1100_????: uop = '{7'd52, CYCLE5};   // LD r, q
                    8'b1110_????: uop = '{7'd53, CYCLE5};   // LDPX r, q
                    8'b1111_????: uop = '{7'd54, CYCLE5};   // LDPY r, q
                    default: ;                              // x9C..x9F, xAC.., xBC.., D0..DF
                endcase
            end
            12'hF0?: uop = '{7'd55, CYCLE7};         // CP r, q
            12'hF1?: uop = '{7'd56, CYCLE7};         // FAN r, q
            12'hF2?: begin
                case (opcode[3:2])
                    2'b10:   uop = '{7'd57, CYCLE7}; // ACPX MX, r
                    2'b11:   uop = '{7'd58, CYCLE7}; // ACPY MY, r
                    default: ;
                endcase
            end
            12'hF3?: begin
                case (opcode[3:2])
                    2'b10:   uop = '{7'd59, CYCLE7}; // SCPX MX, r
                    2'b11:   uop = '{7'd60, CYCLE7}; // SCPY MY, r
                    default: ;
                endcase
            end
            12'hF4?: uop = '{7'd61, CYCLE7};         // SET F, i
            12'hF5?: uop = '{7'd62, CYCLE7};         // RST F, i
            12'hF6?: uop = '{7'd63, CYCLE7};         // INC Mn
            12'hF7?: uop = '{7'd64, CYCLE7};         // DEC Mn
            12'hF8?: uop = '{7'd65, CYCLE5};         // LD Mn, A
            12'hF9?: uop = '{7'd66, CYCLE5};         // LD Mn, B
            12'hFA?: uop = '{7'd67, CYCLE5};         // LD A, Mn
            12'hFB?: uop = '{7'd68, CYCLE5};         // LD B, Mn
            12'hFC?: begin
                casez (opcode[3:0])
                    4'b00??: uop = '{7'd69, CYCLE5}; // PUSH r
                    4'b0100: uop = '{7'd70, CYCLE5}; // PUSH XP
                    4'b0101: uop = '{7'd71, CYCLE5}; // PUSH XH
                    4'b0110: uop = '{7'd72, CYCLE5}; // PUSH XL
                    4'b0111: uop = '{7'd73, CYCLE5}; // PUSH YP
                    4'b1000: uop = '{7'd74, CYCLE5}; // PUSH YH
                    4'b1001: uop = '{7'd75, CYCLE5}; // PUSH YL
                    4'b1010: uop = '{7'd76, CYCLE5}; // PUSH F
                    4'b1011: uop = '{7'd77, CYCLE5}; // DEC SP
                    default: ;
                endcase
            end
            12'hFD?: begin
                casez (opcode[3:0])
                    4'b00??: uop = '{7'd78, CYCLE5}; // POP r
                    4'b0100: uop = '{7'd79, CYCLE5}; // POP XP
                    4'b0101: uop = '{7'd80, CYCLE5}; // POP XH
                    4'b0110: uop = '{7'd81, CYCLE5}; // POP XL
                    4'b0111: uop = '{7'd82, CYCLE5}; // POP YP
                    4'b1000: uop = '{7'd83, CYCLE5}; // POP YH
                    4'b1001: uop = '{7'd84, CYCLE5}; // POP YL
                    4'b1010: uop = '{7'd85, CYCLE5}; // POP F
                    4'b1011: uop = '{7'd86, CYCLE5}; // INC SP
                    4'b1110: uop = '{7'd87, CYCLE12};    // RETS
                    4'b1111: begin                       // RET
                        uop  = '{7'd88, CYCLE7};
                        skip = 1'b1;
                    end
                    default: ;
                endcase
            end
            12'hFE?: begin
                casez (opcode[3:0])
                    4'b00??: uop = '{7'd89, CYCLE5}; // LD SPH, r
                    4'b01??: uop = '{7'd90, CYCLE5}; // LD r, SPH
                    4'b1000: begin                   // JPBA
                        uop  = '{7'd91, CYCLE5};
                        skip = 1'b1;
                    end
                    default: ;
                endcase
            end
            12'hFF?: begin
                casez (opcode[3:0])
                    4'b00??: uop = '{7'd92, CYCLE5}; // LD SPL, r
                    4'b01??: uop = '{7'd93, CYCLE5}; // LD r, SPL
                    4'b1000: uop = '{7'd94, CYCLE5}; // HALT
                    4'b1001: uop = '{7'd95, CYCLE5}; // SLP
                    4'b1011: uop = '{7'd96, CYCLE5}; // NOP5
                    4'b1111: uop = '{7'd97, CYCLE7}; // NOP7
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Reset also decodes, so dec settles on the word at the reset PC
    always_ff @(posedge clk) begin
        if (decode_en || rst) begin
            dec.ucode_addr        <= uop.addr;
            dec.cycle_length      <= uop.len;
            dec.skip_pc_increment <= skip;
            dec.disable_interrupt <= no_int;
            dec.immed             <= opcode[IMMED_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    import core_isa_pkg::*;

    // Decoder output, held until the next decode strobe
    typedef struct packed {
        logic [UCODE_ADDR_W-1:0] ucode_addr;        // Microcode start address
        instr_length             cycle_length;
        logic                    skip_pc_increment; // PC loads page and immed
        logic                    disable_interrupt; // PSET blocks interrupts
        logic [IMMED_W-1:0]      immed;
    } decode_result_t;

    // Reported with the issue strobe
    typedef struct packed {
        logic [OPCODE_W-1:0] pc;                     // Address of the instruction
        decode_result_t      dec;
    } issue_info_t;

    // Sequencer FSM
    typedef enum logic {
        SEQ_DECODE = 1'b0,                           // Waiting for the decode tick
        SEQ_EXEC   = 1'b1                            // Spending the instruction's ticks
    } seq_state_t;

endpackage

`default_nettype wire

//--- core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

    // Opcode and PC share one width
    localparam int OPCODE_W = 12;

    // Entry points into the microcode ROM
    localparam int UCODE_ADDR_W = 7;

    localparam int IMMED_W = 8;                     // Low byte of every opcode
    localparam int PAGE_W  = OPCODE_W - IMMED_W;    // 256-word pages

    // Width of a tick count, enough for the longest instruction
    localparam int TICK_W = 4;

    // Instruction length class; the encoding is not the tick count
    typedef enum logic [1:0] {
        CYCLE5  = 2'd0,
        CYCLE7  = 2'd1,
        CYCLE12 = 2'd2
    } instr_length;

    // Enable ticks spent by each length class
    localparam logic [TICK_W-1:0] TICKS_CYCLE5  = 4'd5;
    localparam logic [TICK_W-1:0] TICKS_CYCLE7  = 4'd7;
    localparam logic [TICK_W-1:0] TICKS_CYCLE12 = 4'd12;

endpackage

`default_nettype wire
